//--- source/reduction_config.svh
// Reduction offload configuration
// Data widths of both offload ports and the operation code width

`ifndef REDUCTION_CONFIG_SVH
`define REDUCTION_CONFIG_SVH

////////////////////////////////
// Data widths
////////////////////////////////

// Signed integers, one word
`define NARROW_DATA_WIDTH 32

// Double precision operands and results
`define WIDE_DATA_WIDTH 64

// Add, multiply, maximum, minimum
`define REDUCTION_OP_WIDTH 2

`endif

//--- source/reduction_pkg.sv
// Reduction offload types
// Operation codes, FPU request layout and data words of both ports

`include "reduction_config.svh"

package reduction_pkg;

  ////////////////////////////////
  // Data words
  ////////////////////////////////

  typedef logic [`NARROW_DATA_WIDTH-1:0] narrow_data_t;
  typedef logic [`WIDE_DATA_WIDTH-1:0]   wide_data_t;

  ////////////////////////////////
  // Operation codes
  ////////////////////////////////

  // Reduction requested by the router
  typedef enum logic [`REDUCTION_OP_WIDTH-1:0] {
    RED_ADD = 2'd0,
    RED_MUL = 2'd1,
    RED_MAX = 2'd2,
    RED_MIN = 2'd3
  } reduction_op_e;

  typedef enum logic [1:0] {
    FPU_ADD    = 2'd0,
    FPU_MUL    = 2'd1,
    FPU_MINMAX = 2'd2
  } fpu_op_e;

  // For minmax, RNE picks the maximum and RTZ the minimum
  typedef enum logic [0:0] {
    RND_RNE = 1'b0,
    RND_RTZ = 1'b1
  } rnd_mode_e;

  typedef struct packed {
    fpu_op_e          op_code;
    rnd_mode_e        rnd_mode;
    wide_data_t [2:0] operands;
  } fpu_req_t;

endpackage

//--- source/offload_if.sv
// Reduction offload port
// Request with op and two operands, response with one result

`timescale 1ns/100ps

interface offload_if #(
  parameter type data_t = reduction_pkg::narrow_data_t
) ();
  import reduction_pkg::*;

  reduction_op_e op;
  data_t         operand1;
  data_t         operand2;
  logic          req_valid;
  logic          req_ready;

  data_t         result;
  logic          resp_valid;
  logic          resp_ready;

  // Router side
  modport requester (
    output op, operand1, operand2, req_valid, resp_ready,
    input  req_ready, result, resp_valid
  );

  // Reduction unit side
  modport unit (
    input  op, operand1, operand2, req_valid, resp_ready,
    output req_ready, result, resp_valid
  );

endinterface

//--- source/spill_cut.sv
// Two-entry register cut on a valid/ready stream
// Registers both valid and ready paths, keeps order under back-pressure

`timescale 1ns/100ps

module spill_cut #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Entry A takes input, entry B holds the older item when stalled
  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Full only when both entries hold data
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

//--- source/narrow_reduction_alu.sv
// Integer reduction unit for the narrow offload port
// Signed add, low-half multiply, max and min into a one-entry result register

`timescale 1ns/100ps

module narrow_reduction_alu (
  input  logic         clk_i,
  input  logic         rst_n_i,
  offload_if.unit      port_if
);
  import reduction_pkg::*;

  narrow_data_t alu_result;
  narrow_data_t result_q;
  logic         result_valid_q;
  logic         req_fire;

  ////////////////////////////////
  // Compute
  ////////////////////////////////

  always_comb begin
    alu_result = '0;
    unique case (port_if.op)
      RED_ADD: begin
        alu_result = port_if.operand1 + port_if.operand2;
      end
      // Low half is the same for signed and unsigned
      RED_MUL: begin
        alu_result = port_if.operand1 * port_if.operand2;
      end
      RED_MAX: begin
        alu_result = ($signed(port_if.operand1) > $signed(port_if.operand2)) ?
                     port_if.operand1 : port_if.operand2;
      end
      RED_MIN: begin
        alu_result = ($signed(port_if.operand1) < $signed(port_if.operand2)) ?
                     port_if.operand1 : port_if.operand2;
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

  ////////////////////////////////
  // Result register
  ////////////////////////////////

  // Accepts when empty or drained this cycle
  assign port_if.req_ready = !result_valid_q || port_if.resp_ready;
  assign req_fire          = port_if.req_valid && port_if.req_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_valid_q <= 1'b0;
    end else if (port_if.req_ready) begin
      result_valid_q <= port_if.req_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      result_q <= alu_result;
    end
  end

  assign port_if.result     = result_q;
  assign port_if.resp_valid = result_valid_q;

endmodule

//--- source/wide_fpu_formatter.sv
// Wide reduction to FPU request formatter
// Builds FPU requests from wide reductions, returns results through cuts

`timescale 1ns/100ps

module wide_fpu_formatter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  offload_if.unit                   port_if,
  output reduction_pkg::fpu_req_t   fpu_req_o,
  output logic                      fpu_req_valid_o,
  input  logic                      fpu_req_ready_i,
  input  reduction_pkg::wide_data_t fpu_result_i,
  input  logic                      fpu_resp_valid_i,
  output logic                      fpu_resp_ready_o
);
  import reduction_pkg::*;

  fpu_req_t fpu_req_d;

  ////////////////////////////////
  // Request format
  ////////////////////////////////

  always_comb begin
    fpu_req_d          = '0;
    fpu_req_d.op_code  = FPU_ADD;
    fpu_req_d.rnd_mode = RND_RNE;
    unique case (port_if.op)
      // Add uses slots 1 and 2, slot 0 is zero
      RED_ADD: begin
        fpu_req_d.operands[1] = port_if.operand1;
        fpu_req_d.operands[2] = port_if.operand2;
      end
      RED_MUL: begin
        fpu_req_d.op_code     = FPU_MUL;
        fpu_req_d.operands[0] = port_if.operand1;
        fpu_req_d.operands[1] = port_if.operand2;
      end
      RED_MAX: begin
        fpu_req_d.op_code     = FPU_MINMAX;
        fpu_req_d.operands[0] = port_if.operand1;
        fpu_req_d.operands[1] = port_if.operand2;
      end
      RED_MIN: begin
        fpu_req_d.op_code     = FPU_MINMAX;
        fpu_req_d.rnd_mode    = RND_RTZ;
        fpu_req_d.operands[0] = port_if.operand1;
        fpu_req_d.operands[1] = port_if.operand2;
      end
      default: begin
        fpu_req_d.op_code = FPU_ADD;
      end
    endcase
  end

  ////////////////////////////////
  // Cuts
  ////////////////////////////////

  spill_cut #(
    .T       (fpu_req_t)
  ) i_req_cut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (port_if.req_valid),
    .ready_o (port_if.req_ready),
    .data_i  (fpu_req_d),
    .valid_o (fpu_req_valid_o),
    .ready_i (fpu_req_ready_i),
    .data_o  (fpu_req_o)
  );

  // FPU result goes back unchanged
  spill_cut #(
    .T       (wide_data_t)
  ) i_resp_cut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (fpu_resp_valid_i),
    .ready_o (fpu_resp_ready_o),
    .data_i  (fpu_result_i),
    .valid_o (port_if.resp_valid),
    .ready_i (port_if.resp_ready),
    .data_o  (port_if.result)
  );

endmodule

//--- source/reduction_offload_tile.sv
// Reduction offload tile
// Integer ALU on the narrow port, FPU formatter on the wide port

`timescale 1ns/100ps

module reduction_offload_tile (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Narrow offload port
  input  reduction_pkg::reduction_op_e narrow_op_i,
  input  reduction_pkg::narrow_data_t  narrow_operand1_i,
  input  reduction_pkg::narrow_data_t  narrow_operand2_i,
  input  logic                         narrow_req_valid_i,
  output logic                         narrow_req_ready_o,
  output reduction_pkg::narrow_data_t  narrow_result_o,
  output logic                         narrow_resp_valid_o,
  input  logic                         narrow_resp_ready_i,
  // Wide offload port
  input  reduction_pkg::reduction_op_e wide_op_i,
  input  reduction_pkg::wide_data_t    wide_operand1_i,
  input  reduction_pkg::wide_data_t    wide_operand2_i,
  input  logic                         wide_req_valid_i,
  output logic                         wide_req_ready_o,
  output reduction_pkg::wide_data_t    wide_result_o,
  output logic                         wide_resp_valid_o,
  input  logic                         wide_resp_ready_i,
  // External FPU
  output reduction_pkg::fpu_req_t      fpu_req_o,
  output logic                         fpu_req_valid_o,
  input  logic                         fpu_req_ready_i,
  input  reduction_pkg::wide_data_t    fpu_result_i,
  input  logic                         fpu_resp_valid_i,
  output logic                         fpu_resp_ready_o
);
  import reduction_pkg::*;

  offload_if #(.data_t(narrow_data_t)) narrow_if ();
  offload_if #(.data_t(wide_data_t))   wide_if ();

  ////////////////////////////////
  // Narrow path
  ////////////////////////////////

  assign narrow_if.op         = narrow_op_i;
  assign narrow_if.operand1   = narrow_operand1_i;
  assign narrow_if.operand2   = narrow_operand2_i;
  assign narrow_if.req_valid  = narrow_req_valid_i;
  assign narrow_if.resp_ready = narrow_resp_ready_i;
  assign narrow_req_ready_o   = narrow_if.req_ready;
  assign narrow_result_o      = narrow_if.result;
  assign narrow_resp_valid_o  = narrow_if.resp_valid;

  narrow_reduction_alu i_narrow_alu (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .port_if (narrow_if.unit)
  );

  ////////////////////////////////
  // Wide path
  ////////////////////////////////

  assign wide_if.op         = wide_op_i;
  assign wide_if.operand1   = wide_operand1_i;
  assign wide_if.operand2   = wide_operand2_i;
  assign wide_if.req_valid  = wide_req_valid_i;
  assign wide_if.resp_ready = wide_resp_ready_i;
  assign wide_req_ready_o   = wide_if.req_ready;
  assign wide_result_o      = wide_if.result;
  assign wide_resp_valid_o  = wide_if.resp_valid;

  wide_fpu_formatter i_wide_formatter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .port_if          (wide_if.unit),
    .fpu_req_o        (fpu_req_o),
    .fpu_req_valid_o  (fpu_req_valid_o),
    .fpu_req_ready_i  (fpu_req_ready_i),
    .fpu_result_i     (fpu_result_i),
    .fpu_resp_valid_i (fpu_resp_valid_i),
    .fpu_resp_ready_o (fpu_resp_ready_o)
  );

endmodule

//--- bench/reduction_offload_sva.sv
// Handshake assertions for the reduction offload tile
// Stalled streams keep their data, valids are known, rounding mode encoding

`timescale 1ns/100ps

module reduction_offload_sva (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        narrow_resp_valid_o,
  input logic                        narrow_resp_ready_i,
  input reduction_pkg::narrow_data_t narrow_result_o,
  input logic                        wide_resp_valid_o,
  input logic                        wide_resp_ready_i,
  input reduction_pkg::wide_data_t   wide_result_o,
  input reduction_pkg::fpu_req_t     fpu_req_o,
  input logic                        fpu_req_valid_o,
  input logic                        fpu_req_ready_i
);
  import reduction_pkg::*;

  int fail_count = 0;

  narrow_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    narrow_resp_valid_o && !narrow_resp_ready_i |=>
      narrow_resp_valid_o && $stable(narrow_result_o))
    else begin
      $error("narrow response changed while stalled");
      fail_count++;
    end

  wide_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wide_resp_valid_o && !wide_resp_ready_i |=>
      wide_resp_valid_o && $stable(wide_result_o))
    else begin
      $error("wide response changed while stalled");
      fail_count++;
    end

  fpu_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fpu_req_valid_o && !fpu_req_ready_i |=> fpu_req_valid_o && $stable(fpu_req_o))
    else begin
      $error("FPU request changed while stalled");
      fail_count++;
    end

  valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({narrow_resp_valid_o, wide_resp_valid_o, fpu_req_valid_o}))
    else begin
      $error("valid output is unknown");
      fail_count++;
    end

  // Toward-zero only selects the minimum
  rtz_minmax: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fpu_req_valid_o && fpu_req_o.rnd_mode == RND_RTZ |-> fpu_req_o.op_code == FPU_MINMAX)
    else begin
      $error("toward-zero rounding on a non-minmax FPU request");
      fail_count++;
    end

endmodule

bind reduction_offload_tile reduction_offload_sva i_sva (.*);

//--- bench/tb_reduction_offload.sv
// Reduction offload tile testbench
// Directed tests on both offload ports, with a small FPU model on the FPU port

`timescale 1ns/100ps

module tb_reduction_offload;
  import reduction_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic          clk_i = 1'b0;
  logic          rst_n_i;
  reduction_op_e narrow_op_i;
  narrow_data_t  narrow_operand1_i;
  narrow_data_t  narrow_operand2_i;
  logic          narrow_req_valid_i;
  logic          narrow_req_ready_o;
  narrow_data_t  narrow_result_o;
  logic          narrow_resp_valid_o;
  logic          narrow_resp_ready_i;
  reduction_op_e wide_op_i;
  wide_data_t    wide_operand1_i;
  wide_data_t    wide_operand2_i;
  logic          wide_req_valid_i;
  logic          wide_req_ready_o;
  wide_data_t    wide_result_o;
  logic          wide_resp_valid_o;
  logic          wide_resp_ready_i;
  fpu_req_t      fpu_req_o;
  logic          fpu_req_valid_o;
  logic          fpu_req_ready_i;
  wide_data_t    fpu_result_i;
  logic          fpu_resp_valid_i;
  logic          fpu_resp_ready_o;

  integer   seed = 19;
  int       error_count = 0;
  int       check_count = 0;
  int       test_count = 0;
  int       cycle_count = 0;
  int       fpu_delay = 1;
  int       fpu_wait;
  logic     fpu_delay_vary = 1'b0;
  fpu_req_t fpu_held;
  fpu_req_t fpu_reqs[$];

  reduction_offload_tile uut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never answered", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // FPU model
  //////////////////////////////

  // Result is the inverse of operand slot 1
  initial begin : fpu_model
    fpu_req_ready_i  = 1'b1;
    fpu_resp_valid_i = 1'b0;
    fpu_result_i     = '0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i && fpu_req_valid_o && fpu_req_ready_i) begin
        fpu_held = fpu_req_o;
        fpu_reqs.push_back(fpu_req_o);
        fpu_wait = fpu_delay_vary ? 1 + $unsigned($random(seed)) % 3 : fpu_delay;
        #1;
        fpu_req_ready_i = 1'b0;
        repeat (fpu_wait - 1) begin
          @(posedge clk_i);
          #1;
        end
        fpu_result_i     = ~fpu_held.operands[1];
        fpu_resp_valid_i = 1'b1;
        @(posedge clk_i);
        while (!fpu_resp_ready_o)
          @(posedge clk_i);
        #1;
        fpu_resp_valid_i = 1'b0;
        fpu_req_ready_i  = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("%s: done, %0d errors", name, error_count - errors_before);
  endtask

  function automatic narrow_data_t narrow_expected(input reduction_op_e op,
                                                   input int a, input int b);
    case (op)
      RED_ADD: return a + b;
      RED_MUL: return a * b;
      RED_MAX: return (a > b) ? a : b;
      default: return (a < b) ? a : b;
    endcase
  endfunction

  // Operand placement and rounding per reduction
  function automatic fpu_req_t fpu_expected(input reduction_op_e op,
                                            input wide_data_t a, input wide_data_t b);
    fpu_req_t req;
    req          = '0;
    req.op_code  = FPU_MINMAX;
    req.rnd_mode = (op == RED_MIN) ? RND_RTZ : RND_RNE;
    req.operands = {64'h0, b, a};
    if (op == RED_ADD) begin
      req.op_code  = FPU_ADD;
      req.operands = {b, a, 64'h0};
    end else if (op == RED_MUL) begin
      req.op_code = FPU_MUL;
    end
    return req;
  endfunction

  task automatic narrow_send(input reduction_op_e op, input narrow_data_t a,
                             input narrow_data_t b);
    narrow_op_i        = op;
    narrow_operand1_i  = a;
    narrow_operand2_i  = b;
    narrow_req_valid_i = 1'b1;
    @(posedge clk_i);
    while (!narrow_req_ready_o)
      @(posedge clk_i);
    #1;
    narrow_req_valid_i = 1'b0;
  endtask

  task automatic wide_send(input reduction_op_e op, input wide_data_t a,
                           input wide_data_t b);
    wide_op_i        = op;
    wide_operand1_i  = a;
    wide_operand2_i  = b;
    wide_req_valid_i = 1'b1;
    @(posedge clk_i);
    while (!wide_req_ready_o)
      @(posedge clk_i);
    #1;
    wide_req_valid_i = 1'b0;
  endtask

  task automatic wide_receive(input string name, input wide_data_t expected);
    @(posedge clk_i);
    while (!wide_resp_valid_o)
      @(posedge clk_i);
    check(name, expected, wide_result_o);
    #1;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    int errors_before;
    errors_before = error_count;
    check("reset narrow_resp_valid", 0, narrow_resp_valid_o);
    check("reset wide_resp_valid", 0, wide_resp_valid_o);
    check("reset fpu_req_valid", 0, fpu_req_valid_o);
    check("reset narrow_req_ready", 1, narrow_req_ready_o);
    check("reset wide_req_ready", 1, wide_req_ready_o);
    check("reset fpu_resp_ready", 1, fpu_resp_ready_o);
    report_test("reset", errors_before);
  endtask

  task automatic test_narrow_ops();
    int           errors_before;
    narrow_data_t a;
    narrow_data_t b;
    narrow_data_t expected;
    errors_before       = error_count;
    narrow_resp_ready_i = 1'b1;
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < 20; i++) begin
        a        = $random(seed);
        b        = $random(seed);
        expected = narrow_expected(reduction_op_e'(op), a, b);
        narrow_send(reduction_op_e'(op), a, b);
        @(posedge clk_i);
        check("narrow_ops valid", 1, narrow_resp_valid_o);
        check("narrow_ops result", expected, narrow_result_o);
        #1;
      end
    end
    report_test("narrow_ops", errors_before);
  endtask

  // One result waits in the ALU while the next request stalls
  task automatic test_narrow_backpressure();
    int           errors_before;
    narrow_data_t a[3];
    narrow_data_t b[3];
    narrow_data_t expected[3];
    errors_before       = error_count;
    narrow_resp_ready_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      a[i]        = $random(seed);
      b[i]        = $random(seed);
      expected[i] = narrow_expected(reduction_op_e'(i), a[i], b[i]);
    end
    narrow_send(reduction_op_e'(0), a[0], b[0]);
    narrow_op_i        = reduction_op_e'(1);
    narrow_operand1_i  = a[1];
    narrow_operand2_i  = b[1];
    narrow_req_valid_i = 1'b1;
    repeat (4) begin
      @(posedge clk_i);
      check("narrow_backpressure ready", 0, narrow_req_ready_o);
      check("narrow_backpressure held", expected[0], narrow_result_o);
    end
    #1;
    narrow_resp_ready_i = 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk_i);
      check("narrow_backpressure valid", 1, narrow_resp_valid_o);
      check("narrow_backpressure result", expected[i], narrow_result_o);
      #1;
      if (i == 0) begin
        narrow_op_i       = reduction_op_e'(2);
        narrow_operand1_i = a[2];
        narrow_operand2_i = b[2];
      end else begin
        narrow_req_valid_i = 1'b0;
      end
    end
    @(posedge clk_i);
    check("narrow_backpressure extra", 0, narrow_resp_valid_o);
    #1;
    report_test("narrow_backpressure", errors_before);
  endtask

  task automatic test_wide_format();
    int         errors_before;
    wide_data_t a;
    wide_data_t b;
    fpu_req_t   expected;
    fpu_req_t   seen;
    errors_before     = error_count;
    wide_resp_ready_i = 1'b1;
    fpu_delay_vary    = 1'b0;
    for (int op = 0; op < 4; op++) begin
      a         = {$random(seed), $random(seed)};
      b         = {$random(seed), $random(seed)};
      expected  = fpu_expected(reduction_op_e'(op), a, b);
      fpu_delay = op % 3 + 1;
      wide_send(reduction_op_e'(op), a, b);
      @(posedge clk_i);
      check("wide_format fpu_req_valid", 1, fpu_req_valid_o);
      #1;
      wide_receive("wide_format result", ~expected.operands[1]);
      seen = fpu_reqs.pop_front();
      check("wide_format op_code", expected.op_code, seen.op_code);
      check("wide_format rnd_mode", expected.rnd_mode, seen.rnd_mode);
      for (int s = 0; s < 3; s++)
        check("wide_format operand", expected.operands[s], seen.operands[s]);
    end
    report_test("wide_format", errors_before);
  endtask

  task automatic test_wide_results();
    int            errors_before;
    reduction_op_e ops[6];
    wide_data_t    a[6];
    wide_data_t    b[6];
    wide_data_t    expected[6];
    fpu_req_t      req;
    errors_before     = error_count;
    fpu_delay_vary    = 1'b1;
    wide_resp_ready_i = 1'b0;
    for (int i = 0; i < 6; i++) begin
      ops[i]      = reduction_op_e'($unsigned($random(seed)) % 4);
      a[i]        = {$random(seed), $random(seed)};
      b[i]        = {$random(seed), $random(seed)};
      req         = fpu_expected(ops[i], a[i], b[i]);
      expected[i] = ~req.operands[1];
    end
    fork
      begin
        for (int i = 0; i < 6; i++)
          wide_send(ops[i], a[i], b[i]);
      end
      begin
        repeat (10) @(posedge clk_i);
        check("wide_results held valid", 1, wide_resp_valid_o);
        check("wide_results held result", expected[0], wide_result_o);
        #1;
        wide_resp_ready_i = 1'b1;
        for (int i = 0; i < 6; i++)
          wide_receive("wide_results result", expected[i]);
      end
    join
    check("wide_results request count", 6, fpu_reqs.size());
    fpu_reqs.delete();
    report_test("wide_results", errors_before);
  endtask

  initial begin
    rst_n_i             = 1'b0;
    narrow_op_i         = RED_ADD;
    narrow_operand1_i   = '0;
    narrow_operand2_i   = '0;
    narrow_req_valid_i  = 1'b0;
    narrow_resp_ready_i = 1'b1;
    wide_op_i           = RED_ADD;
    wide_operand1_i     = '0;
    wide_operand2_i     = '0;
    wide_req_valid_i    = 1'b0;
    wide_resp_ready_i   = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    test_reset();
    test_narrow_ops();
    test_narrow_backpressure();
    test_wide_format();
    test_wide_results();
    if (uut.i_sva.fail_count != 0) begin
      $display("Handshake assertions failed %0d times", uut.i_sva.fail_count);
      error_count += uut.i_sva.fail_count;
    end
    $display("Ran %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+source
source/reduction_pkg.sv
source/offload_if.sv
source/spill_cut.sv
source/narrow_reduction_alu.sv
source/wide_fpu_formatter.sv
source/reduction_offload_tile.sv
bench/reduction_offload_sva.sv
bench/tb_reduction_offload.sv

//--- Makefile
# Verilator simulation of the reduction offload tile

TOP = tb_reduction_offload

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
